// ==== rename_pkg.sv ====
package rename_pkg;

    // architectural register space
    localparam int ar_count = 32;
    localparam int ar_width = 5;

    // physical register space
    localparam int pr_count = 64;
    localparam int pr_width = 6;

    localparam int lane_count = 3;  // rename, retire and cdb width

    // every physical tag not held by the arch map sits in the free list
    localparam int free_count     = pr_count - ar_count;
    localparam int free_ptr_width = 5;
    localparam int free_cnt_width = 6;  // holds 0 to free_count

endpackage

// ==== map_entry.sv ====
`timescale 1ns/1ps

module map_entry #(
    parameter int reset_tag = 0
) (
    input  logic                                                      clock,
    input  logic                                                      reset,
    input  logic                                                      write,
    input  logic                                                      recover,
    input  logic [rename_pkg::pr_width-1:0]                           write_tag,
    input  logic [rename_pkg::pr_width-1:0]                           arch_tag,
    input  logic [rename_pkg::lane_count-1:0]                         cdb_valid,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] cdb_tag,
    output logic [rename_pkg::pr_width-1:0]                           tag,
    output logic                                                      ready
);
    import rename_pkg::*;

    logic cdb_hit;

    always_comb begin
        cdb_hit = 1'b0;
        for (int l = 0; l < lane_count; l++) begin
            if (cdb_valid[l] && cdb_tag[l] == tag) begin
                cdb_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            tag   <= pr_width'(reset_tag);  // identity mapping
            ready <= 1'b1;
        end else if (recover) begin
            tag   <= arch_tag;
            ready <= 1'b1;
        end else if (write) begin
            tag   <= write_tag;
            ready <= 1'b0;  // rename beats a same-cycle wakeup
        end else if (cdb_hit) begin
            ready <= 1'b1;
        end
    end

    // map_table must drop renames during a recovery cycle
    a_no_write_on_recover: assert property (
        @(posedge clock) disable iff (reset) !(write && recover)
    );

endmodule

// ==== map_table.sv ====
`timescale 1ns/1ps

module map_table (
    input  logic                                                        clock,
    input  logic                                                        reset,
    input  logic                                                        recover,
    input  logic                                                        stall,
    input  logic [rename_pkg::lane_count-1:0]                           dest_valid,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::ar_width-1:0] dest_ar,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] tnew,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::ar_width-1:0] src1_ar,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::ar_width-1:0] src2_ar,
    input  logic [rename_pkg::lane_count-1:0]                           cdb_valid,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] cdb_tag,
    input  logic [rename_pkg::ar_count-1:0][rename_pkg::pr_width-1:0]   arch_map,
    output logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] src1_tag,
    output logic [rename_pkg::lane_count-1:0]                           src1_ready,
    output logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] src2_tag,
    output logic [rename_pkg::lane_count-1:0]                           src2_ready,
    output logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] told
);
    import rename_pkg::*;

    logic [ar_count-1:0]               entry_write;
    logic [ar_count-1:0][pr_width-1:0] entry_write_tag;
    logic [ar_count-1:0][pr_width-1:0] entry_tag;
    logic [ar_count-1:0]               entry_ready;
    logic [lane_count-1:0]             zero_dest;
    logic                              rename_en;

    assign rename_en = !stall && !recover;

    // write port decode, later lanes overwrite earlier ones
    always_comb begin
        for (int e = 0; e < ar_count; e++) begin
            entry_write[e]     = 1'b0;
            entry_write_tag[e] = '0;
            for (int l = 0; l < lane_count; l++) begin
                if (rename_en && dest_valid[l] && dest_ar[l] == ar_width'(e)) begin
                    entry_write[e]     = 1'b1;
                    entry_write_tag[e] = tnew[l];
                end
            end
        end
    end

    for (genvar e = 0; e < ar_count; e++) begin : g_entry
        map_entry #(
            .reset_tag (e)
        ) i_map_entry (
            .clock     (clock),
            .reset     (reset),
            .write     (entry_write[e]),
            .recover   (recover),
            .write_tag (entry_write_tag[e]),
            .arch_tag  (arch_map[e]),
            .cdb_valid (cdb_valid),
            .cdb_tag   (cdb_tag),
            .tag       (entry_tag[e]),
            .ready     (entry_ready[e])
        );
    end

    // lookups see the state before this cycle's writes
    always_comb begin
        for (int l = 0; l < lane_count; l++) begin
            src1_tag[l]   = entry_tag[src1_ar[l]];
            src1_ready[l] = entry_ready[src1_ar[l]];
            src2_tag[l]   = entry_tag[src2_ar[l]];
            src2_ready[l] = entry_ready[src2_ar[l]];
            told[l]       = entry_tag[dest_ar[l]];
            zero_dest[l]  = dest_valid[l] && dest_ar[l] == '0;
        end
    end

    // r0 is hardwired, its tag must never leave the arch map
    a_no_zero_dest: assert property (
        @(posedge clock) disable iff (reset) zero_dest == '0
    );

endmodule

// ==== arch_map_table.sv ====
`timescale 1ns/1ps

module arch_map_table (
    input  logic                                                        clock,
    input  logic                                                        reset,
    input  logic [rename_pkg::lane_count-1:0]                           retire_valid,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::ar_width-1:0] retire_ar,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] retire_tnew,
    output logic [rename_pkg::ar_count-1:0][rename_pkg::pr_width-1:0]   arch_map
);
    import rename_pkg::*;

    logic [ar_count-1:0][pr_width-1:0] arch_reg;

    // arch_map is the view after this cycle's retires, which is what
    // recovery has to load into the speculative map
    always_comb begin
        arch_map = arch_reg;
        for (int l = 0; l < lane_count; l++) begin
            if (retire_valid[l]) begin
                arch_map[retire_ar[l]] = retire_tnew[l];  // higher lane wins
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ar_count; i++) begin
                arch_reg[i] <= pr_width'(i);
            end
        end else begin
            arch_reg <= arch_map;
        end
    end

endmodule

// ==== free_list.sv ====
`timescale 1ns/1ps

module free_list (
    input  logic                                                        clock,
    input  logic                                                        reset,
    input  logic                                                        recover,
    input  logic [rename_pkg::lane_count-1:0]                           dest_valid,
    input  logic [rename_pkg::lane_count-1:0]                           retire_valid,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] retire_told,
    output logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] tnew,
    output logic                                                        stall
);
    import rename_pkg::*;

    logic [free_count-1:0][pr_width-1:0]       queue;
    logic [free_ptr_width-1:0]                 head;         // speculative
    logic [free_ptr_width-1:0]                 commit_head;
    logic [free_ptr_width-1:0]                 tail;
    logic [free_cnt_width-1:0]                 count;        // free tags at head
    logic [free_cnt_width-1:0]                 alloc_req;
    logic [free_cnt_width-1:0]                 alloc_cnt;
    logic [free_cnt_width-1:0]                 retire_cnt;
    logic [lane_count-1:0][free_ptr_width-1:0] alloc_idx;
    logic [lane_count-1:0][free_ptr_width-1:0] push_idx;
    logic                                      allocate;

    // valid lanes take consecutive slots, lane 0 first
    always_comb begin
        alloc_req  = '0;
        retire_cnt = '0;
        for (int l = 0; l < lane_count; l++) begin
            alloc_idx[l] = head + alloc_req[free_ptr_width-1:0];
            push_idx[l]  = tail + retire_cnt[free_ptr_width-1:0];
            tnew[l]      = queue[alloc_idx[l]];
            alloc_req    = alloc_req + free_cnt_width'(dest_valid[l]);
            retire_cnt   = retire_cnt + free_cnt_width'(retire_valid[l]);
        end
    end

    assign stall     = alloc_req > count;
    assign allocate  = !stall && !recover;
    assign alloc_cnt = allocate ? alloc_req : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < free_count; i++) begin
                queue[i] <= pr_width'(ar_count + i);  // tags 32 to 63
            end
            head        <= '0;
            commit_head <= '0;
            tail        <= '0;
            count       <= free_cnt_width'(free_count);
        end else begin
            for (int l = 0; l < lane_count; l++) begin
                if (retire_valid[l]) begin
                    queue[push_idx[l]] <= retire_told[l];
                end
            end
            tail        <= tail + retire_cnt[free_ptr_width-1:0];
            commit_head <= commit_head + retire_cnt[free_ptr_width-1:0];
            if (recover) begin
                // each retire pushes one told, so the committed list stays full
                head  <= commit_head + retire_cnt[free_ptr_width-1:0];
                count <= free_cnt_width'(free_count);
            end else begin
                head  <= head + alloc_cnt[free_ptr_width-1:0];
                count <= count - alloc_cnt + retire_cnt;
            end
        end
    end

    // a retire without a matching earlier allocation would overflow here
    a_count_bound: assert property (
        @(posedge clock) disable iff (reset) count <= free_cnt_width'(free_count)
    );

endmodule

// ==== rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage (
    input  logic                                                        clock,
    input  logic                                                        reset,
    input  logic [rename_pkg::lane_count-1:0]                           dest_valid,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::ar_width-1:0] dest_ar,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::ar_width-1:0] src1_ar,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::ar_width-1:0] src2_ar,
    input  logic [rename_pkg::lane_count-1:0]                           cdb_valid,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] cdb_tag,
    input  logic [rename_pkg::lane_count-1:0]                           retire_valid,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::ar_width-1:0] retire_ar,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] retire_tnew,
    input  logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] retire_told,
    input  logic                                                        recover,
    output logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] src1_tag,
    output logic [rename_pkg::lane_count-1:0]                           src1_ready,
    output logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] src2_tag,
    output logic [rename_pkg::lane_count-1:0]                           src2_ready,
    output logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] tnew,
    output logic [rename_pkg::lane_count-1:0][rename_pkg::pr_width-1:0] told,
    output logic                                                        stall
);
    import rename_pkg::*;

    logic [ar_count-1:0][pr_width-1:0] arch_map;  // post-retire committed map

    free_list i_free_list (
        .clock        (clock),
        .reset        (reset),
        .recover      (recover),
        .dest_valid   (dest_valid),
        .retire_valid (retire_valid),
        .retire_told  (retire_told),
        .tnew         (tnew),
        .stall        (stall)
    );

    map_table i_map_table (
        .clock      (clock),
        .reset      (reset),
        .recover    (recover),
        .stall      (stall),
        .dest_valid (dest_valid),
        .dest_ar    (dest_ar),
        .tnew       (tnew),
        .src1_ar    (src1_ar),
        .src2_ar    (src2_ar),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .arch_map   (arch_map),
        .src1_tag   (src1_tag),
        .src1_ready (src1_ready),
        .src2_tag   (src2_tag),
        .src2_ready (src2_ready),
        .told       (told)
    );

    arch_map_table i_arch_map_table (
        .clock        (clock),
        .reset        (reset),
        .retire_valid (retire_valid),
        .retire_ar    (retire_ar),
        .retire_tnew  (retire_tnew),
        .arch_map     (arch_map)
    );

endmodule

// ==== rename_tb.sv ====
`timescale 1ns/1ps

module rename_tb;
    import rename_pkg::*;

    localparam int test_cycles = 4 + 6 + 9 + 12 + 16 + 9 + 62;  // reset plus each test
    localparam int timeout_ns  = (test_cycles + 100) * 20;

    logic clock;
    logic reset;
    logic [lane_count-1:0]               dest_valid, cdb_valid, retire_valid;
    logic [lane_count-1:0][ar_width-1:0] dest_ar, src1_ar, src2_ar, retire_ar;
    logic [lane_count-1:0][pr_width-1:0] cdb_tag, retire_tnew, retire_told;
    logic                                recover;
    logic [lane_count-1:0][pr_width-1:0] src1_tag, src2_tag, tnew, told;
    logic [lane_count-1:0]               src1_ready, src2_ready;
    logic                                stall;

    // reference model
    logic [pr_width-1:0] m_spec [ar_count];
    logic                m_ready [ar_count];
    logic [pr_width-1:0] m_arch [ar_count];
    logic [pr_width-1:0] m_fq [free_count];
    int                  m_head, m_commit, m_tail, m_count;
    int                  if_ar[$], if_tnew[$], if_told[$];  // renamed, not yet retired

    logic [lane_count-1:0][pr_width-1:0] exp_src1_tag, exp_src2_tag, exp_tnew, exp_told;
    logic [lane_count-1:0]               exp_src1_ready, exp_src2_ready;
    logic                                exp_stall;
    logic                                model_unique;
    logic [lane_count-1:0][ar_width-1:0] cdb_ar;         // registers whose tags went on the cdb
    logic                                group_stalled;  // last group was not taken

    integer seed = 95;
    int     errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     errors_at_start;

    rename_stage i_rename_stage (.*);

    always #10 clock = ~clock;

    always_comb begin
        int n;
        n = 0;
        for (int l = 0; l < lane_count; l++) begin
            exp_tnew[l]       = m_fq[(m_head + n) % free_count];
            n                 = n + int'(dest_valid[l]);
            exp_src1_tag[l]   = m_spec[src1_ar[l]];
            exp_src1_ready[l] = m_ready[src1_ar[l]];
            exp_src2_tag[l]   = m_spec[src2_ar[l]];
            exp_src2_ready[l] = m_ready[src2_ar[l]];
            exp_told[l]       = m_spec[dest_ar[l]];
        end
        exp_stall = n > m_count;
    end

    // arch map plus the whole free queue must cover each tag once
    always_comb begin
        logic [pr_count-1:0] seen;
        seen = '0;
        model_unique = 1'b1;
        for (int i = 0; i < ar_count; i++) begin
            if (seen[m_arch[i]]) model_unique = 1'b0;
            seen[m_arch[i]] = 1'b1;
        end
        for (int i = 0; i < free_count; i++) begin
            if (seen[m_fq[i]]) model_unique = 1'b0;
            seen[m_fq[i]] = 1'b1;
        end
    end

    always @(posedge clock) begin
        logic [lane_count-1:0][pr_width-1:0] snap_tnew, snap_told;
        logic                                snap_stall;
        int                                  n;
        int                                  rc;
        snap_tnew  = exp_tnew;
        snap_told  = exp_told;
        snap_stall = exp_stall;
        n  = 0;
        rc = 0;
        if (reset) begin
            for (int i = 0; i < ar_count; i++) begin
                m_spec[i]  = pr_width'(i);
                m_ready[i] = 1'b1;
                m_arch[i]  = pr_width'(i);
                m_fq[i]    = pr_width'(ar_count + i);
            end
            m_head        = 0;
            m_commit      = 0;
            m_tail        = 0;
            m_count       = free_count;
            group_stalled = 1'b0;
            if_ar.delete();
            if_tnew.delete();
            if_told.delete();
        end else begin
            group_stalled = snap_stall && !recover;
            for (int l = 0; l < lane_count; l++) begin
                if (retire_valid[l]) begin
                    m_arch[retire_ar[l]] = retire_tnew[l];
                    m_fq[m_tail] = retire_told[l];
                    m_tail   = (m_tail + 1) % free_count;
                    m_commit = (m_commit + 1) % free_count;
                    rc++;
                    void'(if_ar.pop_front());
                    void'(if_tnew.pop_front());
                    void'(if_told.pop_front());
                end
            end
            if (recover) begin
                for (int i = 0; i < ar_count; i++) begin
                    m_spec[i]  = m_arch[i];
                    m_ready[i] = 1'b1;
                end
                m_head  = m_commit;
                m_count = free_count;
                if_ar.delete();  // squashed
                if_tnew.delete();
                if_told.delete();
            end else begin
                for (int i = 0; i < ar_count; i++) begin
                    for (int l = 0; l < lane_count; l++) begin
                        if (cdb_valid[l] && cdb_tag[l] == m_spec[i]) m_ready[i] = 1'b1;
                    end
                end
                for (int l = 0; l < lane_count; l++) begin
                    if (!snap_stall && dest_valid[l]) begin
                        if_ar.push_back(int'(dest_ar[l]));
                        if_tnew.push_back(int'(snap_tnew[l]));
                        if_told.push_back(int'(snap_told[l]));
                        m_spec[dest_ar[l]]  = snap_tnew[l];
                        m_ready[dest_ar[l]] = 1'b0;  // rename beats wakeup
                        n++;
                    end
                end
                m_head  = (m_head + n) % free_count;
                m_count = m_count - n + rc;
            end
        end
    end

    task automatic log_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    a_src1: assert property (@(posedge clock) disable iff (reset)
        src1_tag == exp_src1_tag && src1_ready == exp_src1_ready)
        else log_error("source 1 lookup differs from model");
    a_src2: assert property (@(posedge clock) disable iff (reset)
        src2_tag == exp_src2_tag && src2_ready == exp_src2_ready)
        else log_error("source 2 lookup differs from model");
    a_stall: assert property (@(posedge clock) disable iff (reset) stall == exp_stall)
        else log_error("stall differs from model");
    a_tnew: assert property (@(posedge clock) disable iff (reset) tnew == exp_tnew)
        else log_error("tnew differs from free list order");
    a_told: assert property (@(posedge clock) disable iff (reset) told == exp_told)
        else log_error("told differs from prior mapping");
    a_unique: assert property (@(posedge clock) disable iff (reset) model_unique)
        else log_error("a physical tag is held twice");

    function automatic logic [ar_width-1:0] rand_ar();
        int r;
        r = $random(seed);
        return ar_width'((r % 31 + 31) % 31 + 1);  // never r0
    endfunction

    task automatic sweep_sources();
        for (int c = 0; c < 6; c++) begin  // all 32 registers
            for (int l = 0; l < lane_count; l++) begin
                src1_ar[l] = ar_width'(c * 6 + l);
                src2_ar[l] = ar_width'(c * 6 + 3 + l);
            end
            @(negedge clock);
        end
    endtask

    task automatic set_sources();
        for (int l = 0; l < lane_count; l++) begin
            src1_ar[l] = dest_ar[l];  // last group's dests
            src2_ar[l] = cdb_ar[l];   // last cycle's wakeup targets
        end
    endtask

    task automatic set_renames(input int k, input bit dup_last);
        logic [ar_width-1:0] r;
        bit                  clash;
        if (group_stalled) return;  // hold the group while stalled
        dest_valid = '0;
        for (int l = 0; l < k; l++) begin
            do begin
                r = rand_ar();
                clash = 1'b0;
                for (int j = 0; j < l; j++) begin
                    if (dest_ar[j] == r) clash = 1'b1;
                end
            end while (clash);
            if (dup_last && l > 0 && l == k - 1) r = dest_ar[0];  // repeats lane 0
            dest_ar[l]    = r;
            dest_valid[l] = 1'b1;
        end
    endtask

    task automatic set_cdb();
        for (int l = 0; l < lane_count; l++) begin
            cdb_valid[l] = 1'($random(seed));
            cdb_ar[l]    = (l == 0 && dest_valid[0]) ? dest_ar[0] : rand_ar();
            cdb_tag[l]   = m_spec[cdb_ar[l]];  // lane 0 races a rename of its entry
        end
    endtask

    task automatic set_retires(input int k);
        retire_valid = '0;
        if (k > if_ar.size()) k = if_ar.size();
        for (int l = 0; l < k; l++) begin
            retire_valid[l] = 1'b1;
            retire_ar[l]    = ar_width'(if_ar[l]);
            retire_tnew[l]  = pr_width'(if_tnew[l]);
            retire_told[l]  = pr_width'(if_told[l]);
        end
    endtask

    task automatic idle_inputs();
        dest_valid   = '0;
        cdb_valid    = '0;
        retire_valid = '0;
        recover      = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) tests_passed++;
        else tests_failed++;
        $display("%s: %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    initial begin
        #(timeout_ns);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        dest_ar     = '0;
        src1_ar     = '0;
        src2_ar     = '0;
        retire_ar   = '0;
        cdb_tag     = '0;
        retire_tnew = '0;
        retire_told = '0;
        cdb_ar      = '0;
        idle_inputs();
        errors_at_start = 0;
        repeat (4) @(posedge clock);
        @(negedge clock) reset = 1'b0;

        sweep_sources();
        finish_test("reset state");

        for (int c = 0; c < 8; c++) begin
            set_sources();
            set_renames(3, 1'b1);
            set_cdb();
            @(negedge clock);
        end
        idle_inputs();
        recover = 1'b1;  // drop groups with repeated dests
        @(negedge clock) recover = 1'b0;
        finish_test("random renames");

        for (int c = 0; c < 12; c++) begin
            set_sources();
            set_renames(2, 1'b0);
            set_cdb();
            cdb_valid = 3'b111;
            @(negedge clock);
        end
        finish_test("wakeup");

        idle_inputs();
        for (int c = 0; c < 16; c++) begin
            set_sources();
            set_renames(3, 1'b0);
            if (c >= 13) set_retires(3);
            else retire_valid = '0;
            @(negedge clock);
        end
        finish_test("stall");

        idle_inputs();
        for (int c = 0; c < 3; c++) begin
            set_sources();
            set_retires(2);
            recover = (c == 2);
            @(negedge clock);
        end
        idle_inputs();
        sweep_sources();
        finish_test("retire and recover");

        for (int c = 0; c < 60; c++) begin
            set_sources();
            set_renames(($random(seed) & 32'h7fffffff) % 4, 1'b0);
            set_cdb();
            set_retires(($random(seed) & 32'h7fffffff) % 4);
            @(negedge clock);
        end
        idle_inputs();
        repeat (2) @(negedge clock);
        finish_test("free list wrap");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rename_stage.f ====
rename_pkg.sv
map_entry.sv
map_table.sv
arch_map_table.sv
free_list.sv
rename_stage.sv
rename_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rename testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing \
    -f rename_stage.f \
    --top-module rename_tb \
    -o sim_rename
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_rename > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
